// File: tb.f
+incdir+verilog
verilog/router_pkg.sv
verilog/router_fsm.sv
verilog/router_reg.sv
verilog/router_sync.sv
verilog/router_fifo.sv
verilog/router_top.sv
test/router_tb.sv

// File: Bender.yml
package:
  name: router

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/router_pkg.sv
      - verilog/router_fsm.sv
      - verilog/router_reg.sv
      - verilog/router_sync.sv
      - verilog/router_fifo.sv
      - verilog/router_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/router_tb.sv

// File: test/router_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_consts.svh"

module router_tb;
  import router_pkg::*;

  localparam int NUM_RANDOM   = 24;
  localparam int NUM_DIRECTED = 6;
  localparam int CYCLE_LIMIT  = 200 * (NUM_RANDOM + NUM_DIRECTED) + 500;

  logic                     clk       = 1'b0;
  logic                     rst       = 1'b0;
  logic                     pkt_valid = 1'b0;
  byte_t                    data_in   = 8'h00;
  logic [`ROUTER_PORTS-1:0] read_enb  = '0;
  logic [`ROUTER_PORTS-1:0] valid_out;
  byte_t                    dout [`ROUTER_PORTS];
  logic                     busy;
  logic                     err;

  logic [31:0]              lfsr;
  logic [`ROUTER_PORTS-1:0] read_on;
  logic [1:0]               phase;
  int                       cycle;
  int                       packets;
  int                       value_errors = 0;
  int                       check_errors = 0;
  byte_t                    sb_q [`ROUTER_PORTS][$];  // Expected bytes, header first.
  int                       exp_left [`ROUTER_PORTS];
  byte_t                    exp_byte [`ROUTER_PORTS];
  int                       idle [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0] popped;
  logic [`ROUTER_PORTS-1:0] extra;
  logic [`ROUTER_PORTS-1:0] flush_due;
  logic                     err_check;
  logic                     exp_err;
  logic                     stall_check;
  logic                     end_check;

  router_top DUT (
    .clk        (clk),
    .rst        (rst),
    .pkt_valid  (pkt_valid),
    .data_in    (data_in),
    .read_enb_0 (read_enb[0]),
    .read_enb_1 (read_enb[1]),
    .read_enb_2 (read_enb[2]),
    .data_out_0 (dout[0]),
    .data_out_1 (dout[1]),
    .data_out_2 (dout[2]),
    .valid_out_0(valid_out[0]),
    .valid_out_1(valid_out[1]),
    .valid_out_2(valid_out[2]),
    .busy       (busy),
    .err        (err)
  );

  always #2 clk = ~clk;  // 4 ns period.

  // Galois LFSR, one step per bit taken.
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Drive one byte and return on the edge that takes it.
  task automatic present(input byte_t b, input logic v);
    data_in   <= b;
    pkt_valid <= v;
    do begin
      @(posedge clk);
    end while (busy);
  endtask

  task automatic send_packet(input addr_t addr, input int len, input logic corrupt);
    byte_t header;
    byte_t payload;
    byte_t parity;
    header = {6'(len), addr};
    parity = header;
    sb_q[addr].push_back(header);
    present(header, 1'b1);
    for (int k = 0; k < len; k++) begin
      payload = rand_bits(8);
      parity  = parity ^ payload;
      sb_q[addr].push_back(payload);
      present(payload, 1'b1);
    end
    present(corrupt ? ~parity : parity, 1'b0);
    present(8'h00, 1'b0);  // Back in decode, err has settled.
    err_check <= 1'b1;
    exp_err   <= corrupt;
    @(posedge clk);
    err_check <= 1'b0;
    packets++;
  endtask

  // Hold a port unread, then resume after a number of cycles.
  task automatic resume_read(input int port, input int cycles);
    repeat (cycles) @(posedge clk);
    stall_check   <= 1'b1;
    read_on[port] <= 1'b1;
    @(posedge clk);
    stall_check   <= 1'b0;
  endtask

  // Readers skip one cycle in four.
  always @(posedge clk) begin
    if (!rst) begin
      phase    <= '0;
      read_enb <= '0;
    end else begin
      phase    <= phase + 1'b1;
      read_enb <= (phase != 2'd0) ? read_on : '0;
    end
  end

  // Scoreboard and idle-port model.
  always @(posedge clk) begin
    for (int i = 0; i < `ROUTER_PORTS; i++) begin
      popped[i]    <= 1'b0;
      flush_due[i] <= 1'b0;
      if (!rst) begin
        extra[i]    <= 1'b0;
        exp_left[i] <= 0;
        idle[i]      = 0;
      end else begin
        if (flush_due[i]) begin
          sb_q[i].delete();
        end
        if (read_enb[i] && valid_out[i]) begin
          popped[i] <= 1'b1;
          extra[i]  <= (sb_q[i].size() == 0);
          if (sb_q[i].size() != 0) begin
            exp_byte[i] <= sb_q[i].pop_front();
          end
        end
        if (valid_out[i] && !read_enb[i]) begin
          idle[i] = idle[i] + 1;
          if (idle[i] == `ROUTER_FLUSH_CYCLES) begin
            flush_due[i] <= 1'b1;
            idle[i]       = 0;
          end
        end else begin
          idle[i] = 0;
        end
        exp_left[i] <= sb_q[i].size();
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) $rose(rst) |-> !busy && !err && valid_out == '0)
    else begin
      check_errors++;
      $display("busy, err or a valid_out is not low after reset at %0t ns", $time);
    end

  a_err: assert property (@(posedge clk) disable iff (!rst) err_check |-> err == exp_err)
    else begin
      value_errors++;
      $display("Error: %0t ns err expected %b got %b", $time, $sampled(exp_err), $sampled(err));
    end

  a_stall: assert property (@(posedge clk) disable iff (!rst) stall_check |-> busy)
    else begin
      check_errors++;
      $display("busy was low at %0t ns while the source had to be held off", $time);
    end

  for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_port
    a_data: assert property (@(posedge clk) disable iff (!rst)
      popped[i] && !extra[i] |-> dout[i] == exp_byte[i])
      else begin
        value_errors++;
        $display("Error: %0t ns data_out_%0d expected %h got %h", $time, i,
                 $sampled(exp_byte[i]), $sampled(dout[i]));
      end

    a_extra: assert property (@(posedge clk) disable iff (!rst) popped[i] |-> !extra[i])
      else begin
        check_errors++;
        $display("Port %0d delivered a byte that was never sent at %0t ns", i, $time);
      end

    a_stray: assert property (@(posedge clk) disable iff (!rst) valid_out[i] |-> exp_left[i] != 0)
      else begin
        check_errors++;
        $display("Port %0d shows valid data with no packet sent to it at %0t ns", i, $time);
      end

    a_flush: assert property (@(posedge clk) disable iff (!rst) flush_due[i] |=> !valid_out[i])
      else begin
        check_errors++;
        $display("Port %0d was not flushed after %0d idle cycles", i, `ROUTER_FLUSH_CYCLES);
      end

    a_drained: assert property (@(posedge clk) disable iff (!rst)
      end_check |-> exp_left[i] == 0 && !valid_out[i])
      else begin
        check_errors++;
        $display("Port %0d still holds %0d expected bytes at the end", i, $sampled(exp_left[i]));
      end
  end

  initial begin
    cycle = 0;
    while (cycle < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle = cycle + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    addr_t addr;
    int    len;
    lfsr        = 32'h34d5;
    packets     = 0;
    read_on     = '0;
    err_check   = 1'b0;
    exp_err     = 1'b0;
    stall_check = 1'b0;
    end_check   = 1'b0;
    repeat (4) @(posedge clk);
    rst     <= 1'b1;
    read_on <= '1;
    @(posedge clk);

    send_packet(2'd0, 7, 1'b0);
    send_packet(2'd1, 4, 1'b1);

    read_on[1] <= 1'b0;  // Long packet fills port 1.
    fork
      send_packet(2'd1, 40, 1'b0);
      resume_read(1, 24);
    join

    read_on[2] <= 1'b0;  // Second packet waits for port 2 to drain.
    send_packet(2'd2, 5, 1'b0);
    fork
      send_packet(2'd2, 12, 1'b1);
      resume_read(2, 8);
    join

    read_on[0] <= 1'b0;  // Port 0 is left unread until flushed.
    send_packet(2'd0, 3, 1'b0);
    do begin
      @(posedge clk);
    end while (valid_out[0]);
    read_on[0] <= 1'b1;

    for (int n = 0; n < NUM_RANDOM; n++) begin
      addr = addr_t'(rand_bits(2) % 3);
      len  = rand_bits(6);
      if (len == 0) begin
        len = 1;
      end
      send_packet(addr, len, rand_bits(2) == 2'd0);
    end

    do begin
      @(posedge clk);
    end while (valid_out != '0);
    end_check <= 1'b1;
    @(posedge clk);
    end_check <= 1'b0;
    @(posedge clk);
    $display("Packets: %0d, value errors: %0d, other errors: %0d",
             packets, value_errors, check_errors);
    if (value_errors + check_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/router_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_consts.svh"

module router_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              pkt_valid,
  input  router_pkg::byte_t data_in,
  input  logic              read_enb_0,
  input  logic              read_enb_1,
  input  logic              read_enb_2,
  output router_pkg::byte_t data_out_0,
  output router_pkg::byte_t data_out_1,
  output router_pkg::byte_t data_out_2,
  output logic              valid_out_0,
  output logic              valid_out_1,
  output logic              valid_out_2,
  output logic              busy,
  output logic              err
);
  import router_pkg::*;

  logic detect_addr, lfd_state, ld_state, laf_state, full_state;
  logic rst_int_reg, write_enb_reg;
  logic sel_empty, sel_full, soft_rst_any;
  logic parity_done, low_pkt_valid;
  fifo_word_t fifo_din;

  logic [`ROUTER_PORTS-1:0] empty, full, write_enb, soft_rst, valid_out, read_enb;
  byte_t                    dout [`ROUTER_PORTS];

  assign read_enb  = {read_enb_2, read_enb_1, read_enb_0};
  assign valid_out = ~empty;
  assign {valid_out_2, valid_out_1, valid_out_0} = valid_out;
  assign data_out_0 = dout[0];
  assign data_out_1 = dout[1];
  assign data_out_2 = dout[2];

  router_fsm u_fsm (.*);

  router_reg u_reg (.*);

  router_sync u_sync (.*);

  for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_fifo
    router_fifo u_fifo (
      .clk      (clk),
      .rst      (rst),
      .soft_rst (soft_rst[i]),
      .write_enb(write_enb[i]),
      .read_enb (read_enb[i]),
      .din      (fifo_din),
      .data_out (dout[i]),
      .empty    (empty[i]),
      .full     (full[i])
    );
  end

endmodule

`default_nettype wire

// File: verilog/router_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_consts.svh"

module router_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   soft_rst,
  input  logic                   write_enb,
  input  logic                   read_enb,
  input  router_pkg::fifo_word_t din,
  output router_pkg::byte_t      data_out,
  output logic                   empty,
  output logic                   full
);
  import router_pkg::*;

  fifo_word_t               mem [`ROUTER_FIFO_DEPTH];
  logic [`ROUTER_PTR_W-1:0] wr_ptr;
  logic [`ROUTER_PTR_W-1:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[`ROUTER_PTR_W-1] != rd_ptr[`ROUTER_PTR_W-1]) &&
                 (wr_ptr[`ROUTER_PTR_W-2:0] == rd_ptr[`ROUTER_PTR_W-2:0]);

  always_ff @(posedge clk) begin
    if (write_enb && !full) begin
      mem[wr_ptr[`ROUTER_PTR_W-2:0]] <= din;
    end
    if (read_enb && !empty) begin
      data_out <= mem[rd_ptr[`ROUTER_PTR_W-2:0]].data;  // Registered read.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || soft_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (write_enb && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (read_enb && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!rst)
    write_enb |-> !full);

  // The controller only starts a packet into a drained FIFO.
  a_header_on_empty: assert property (@(posedge clk) disable iff (!rst || soft_rst)
    (write_enb && din.first) |-> empty);

endmodule

`default_nettype wire

// File: verilog/router_sync.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_consts.svh"

module router_sync (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     detect_addr,
  input  logic                     pkt_valid,
  input  logic                     write_enb_reg,
  input  router_pkg::byte_t        data_in,
  input  logic [`ROUTER_PORTS-1:0] empty,
  input  logic [`ROUTER_PORTS-1:0] full,
  input  logic [`ROUTER_PORTS-1:0] valid_out,
  input  logic [`ROUTER_PORTS-1:0] read_enb,
  output logic                     sel_empty,
  output logic                     sel_full,
  output logic                     soft_rst_any,
  output logic [`ROUTER_PORTS-1:0] write_enb,
  output logic [`ROUTER_PORTS-1:0] soft_rst
);
  import router_pkg::*;

  addr_t                     addr_q;
  addr_t                     cur_addr;
  logic                      addr_bad;
  logic [`ROUTER_PORTS-1:0]  addr_hot;
  logic [`ROUTER_TIMER_W-1:0] idle_cnt [`ROUTER_PORTS];

  always_ff @(posedge clk) begin
    if (!rst) begin
      addr_q <= '0;
    end else if (detect_addr && pkt_valid) begin
      addr_q <= data_in[1:0];
    end
  end

  assign cur_addr = detect_addr ? data_in[1:0] : addr_q;
  assign addr_bad = (cur_addr == addr_t'(`ROUTER_PORTS));

  always_comb begin
    for (int i = 0; i < `ROUTER_PORTS; i++) begin
      addr_hot[i] = (cur_addr == addr_t'(i));
    end
  end

  // Address 3 selects no FIFO and shows as both empty and full.
  assign sel_empty    = addr_bad || |(empty & addr_hot);
  assign sel_full     = addr_bad || |(full & addr_hot);
  assign write_enb    = write_enb_reg ? addr_hot : '0;
  assign soft_rst_any = |(soft_rst & addr_hot);

  always_ff @(posedge clk) begin
    if (!rst) begin
      soft_rst <= '0;
      for (int i = 0; i < `ROUTER_PORTS; i++) begin
        idle_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `ROUTER_PORTS; i++) begin
        soft_rst[i] <= 1'b0;
        if (valid_out[i] && !read_enb[i]) begin
          if (idle_cnt[i] == `ROUTER_TIMER_W'(`ROUTER_FLUSH_CYCLES - 1)) begin
            soft_rst[i] <= 1'b1;
            idle_cnt[i] <= '0;
          end else begin
            idle_cnt[i] <= idle_cnt[i] + 1'b1;
          end
        end else begin
          idle_cnt[i] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/router_reg.sv
`timescale 1ns/1ps
`default_nettype none

module router_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  router_pkg::byte_t      data_in,
  input  logic                   pkt_valid,
  input  logic                   detect_addr,
  input  logic                   lfd_state,
  input  logic                   ld_state,
  input  logic                   laf_state,
  input  logic                   full_state,
  input  logic                   rst_int_reg,
  input  logic                   sel_full,
  output router_pkg::fifo_word_t fifo_din,
  output logic                   parity_done,
  output logic                   low_pkt_valid,
  output logic                   err
);
  import router_pkg::*;

  byte_t hold_header;
  byte_t full_byte;
  byte_t parity_byte;
  byte_t calc_parity;
  logic  hdr_accept;

  assign hdr_accept = detect_addr && pkt_valid && (data_in[1:0] != 2'd3);

  // Payload registers.
  always_ff @(posedge clk) begin
    if (hdr_accept) begin
      hold_header <= data_in;
    end
    if (ld_state && pkt_valid && sel_full) begin
      full_byte <= data_in;  // Byte caught by the stall.
    end
    if (ld_state && !pkt_valid) begin
      parity_byte <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      calc_parity   <= '0;
      parity_done   <= 1'b0;
      low_pkt_valid <= 1'b0;
      err           <= 1'b0;
    end else begin
      if (hdr_accept) begin
        calc_parity   <= data_in;
        parity_done   <= 1'b0;
        low_pkt_valid <= 1'b0;
        err           <= 1'b0;
      end else if (ld_state && pkt_valid) begin
        calc_parity <= calc_parity ^ data_in;
      end
      if (ld_state && !pkt_valid) begin
        low_pkt_valid <= 1'b1;
      end
      if (low_pkt_valid && !rst_int_reg) begin
        parity_done <= 1'b1;
      end
      if (rst_int_reg) begin
        err           <= (calc_parity != parity_byte);
        low_pkt_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    if (lfd_state) begin
      fifo_din = '{first: 1'b1, data: hold_header};
    end else if (laf_state) begin
      fifo_din = '{first: 1'b0, data: full_byte};
    end else begin
      fifo_din = '{first: 1'b0, data: data_in};
    end
  end

  // The compare needs the parity byte.
  a_err_after_check: assert property (@(posedge clk) disable iff (!rst)
    rst_int_reg |-> low_pkt_valid);

  // A stall always starts with a caught byte.
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst)
    $rose(full_state) |-> $past(ld_state && pkt_valid && sel_full));

endmodule

`default_nettype wire

// File: verilog/router_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module router_fsm (
  input  logic clk,
  input  logic rst,
  input  logic pkt_valid,
  input  logic sel_empty,
  input  logic sel_full,
  input  logic soft_rst_any,
  input  logic parity_done,
  input  logic low_pkt_valid,
  output logic detect_addr,
  output logic lfd_state,
  output logic ld_state,
  output logic laf_state,
  output logic full_state,
  output logic rst_int_reg,
  output logic write_enb_reg,
  output logic busy
);
  import router_pkg::*;

  router_state_e state;
  router_state_e state_nxt;
  logic          hdr_ok;

  // Address 3 is not a port.
  assign hdr_ok = pkt_valid && !(sel_empty && sel_full);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= DECODE_ADDRESS;
    end else if (soft_rst_any) begin
      state <= DECODE_ADDRESS;  // Abandon the packet.
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      DECODE_ADDRESS: begin
        // Address 3 shows both empty and full, so hdr_ok drops such a header here.
        if (hdr_ok && sel_empty) begin
          state_nxt = LOAD_FIRST_DATA;
        end else if (hdr_ok && sel_full) begin
          state_nxt = WAIT_TILL_EMPTY;
        end else if (hdr_ok && !sel_empty && !sel_full) begin
          state_nxt = WAIT_TILL_EMPTY;
        end
      end
      LOAD_FIRST_DATA: state_nxt = LOAD_DATA;
      LOAD_DATA: begin
        if (!pkt_valid) begin
          state_nxt = LOAD_PARITY;  // Parity byte on the bus.
        end else if (sel_full) begin
          state_nxt = FIFO_FULL_STATE;
        end
      end
      WAIT_TILL_EMPTY: begin
        if (sel_empty) begin
          state_nxt = LOAD_FIRST_DATA;
        end
      end
      FIFO_FULL_STATE: begin
        if (!sel_full) begin
          state_nxt = LOAD_AFTER_FULL;
        end
      end
      LOAD_AFTER_FULL: state_nxt = LOAD_DATA;
      LOAD_PARITY: begin
        state_nxt = low_pkt_valid ? CHECK_PARITY_ERROR : DECODE_ADDRESS;
      end
      CHECK_PARITY_ERROR: begin
        if (parity_done) begin
          state_nxt = DECODE_ADDRESS;
        end
      end
      default: state_nxt = DECODE_ADDRESS;
    endcase
  end

  assign detect_addr = (state == DECODE_ADDRESS);
  assign lfd_state   = (state == LOAD_FIRST_DATA);
  assign ld_state    = (state == LOAD_DATA);
  assign laf_state   = (state == LOAD_AFTER_FULL);
  assign full_state  = (state == FIFO_FULL_STATE);
  assign rst_int_reg = (state == CHECK_PARITY_ERROR);
  assign write_enb_reg = lfd_state || laf_state || (ld_state && pkt_valid && !sel_full);
  assign busy = !(state == DECODE_ADDRESS || state == LOAD_DATA);

  // A packet starts only into a drained FIFO.
  a_start_empty: assert property (@(posedge clk) disable iff (!rst)
    lfd_state |-> sel_empty);

endmodule

`default_nettype wire

// File: verilog/router_pkg.sv
`default_nettype none

package router_pkg;

  typedef logic [7:0] byte_t;

  typedef logic [1:0] addr_t;

  typedef struct packed {
    logic  first;  // Set on the header byte.
    byte_t data;
  } fifo_word_t;

  typedef enum logic [2:0] {
    DECODE_ADDRESS     = 3'b000,
    LOAD_FIRST_DATA    = 3'b001,
    LOAD_DATA          = 3'b010,
    WAIT_TILL_EMPTY    = 3'b011,
    CHECK_PARITY_ERROR = 3'b100,
    LOAD_PARITY        = 3'b101,
    FIFO_FULL_STATE    = 3'b110,
    LOAD_AFTER_FULL    = 3'b111
  } router_state_e;

endpackage

`default_nettype wire

// File: verilog/router_consts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// Entries per output FIFO.
`define ROUTER_FIFO_DEPTH 16

// Pointer width with the wrap bit.
`define ROUTER_PTR_W 5

// Number of output ports.
`define ROUTER_PORTS 3

// Idle cycles before an unread port is flushed.
`define ROUTER_FLUSH_CYCLES 30

// Flush timer width.
`define ROUTER_TIMER_W 5

`endif
